// ==== common/decode_pkg.sv ====
/*
 * Shared widths, RV32IM opcode and funct encodings, select enums and the
 * ID/EX payload structs. Used by all decode RTL and the testbench.
 */
package decode_pkg;

    // Widths
    localparam int xlen       = 32;
    localparam int addr_len   = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_func_w = 4;
    localparam int sel_w      = 2;

    // Major opcodes
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    // ALU group funct3, shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_sr      = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_jalr    = 3'b000;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Load and store sizes
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    localparam logic [6:0] funct7_base   = 7'b0000000;
    localparam logic [6:0] funct7_alt    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    typedef enum logic [alu_func_w-1:0] {
        alu_nop, alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_mul, alu_div
    } alu_op_e;

    typedef enum logic [sel_w-1:0] {opsel_rs1, opsel_rs2, opsel_imm, opsel_pc} opsel_e;
    typedef enum logic [sel_w-1:0] {wb_alu, wb_dmem, wb_imm, wb_pc4} wbsel_e;
    typedef enum logic [sel_w-1:0] {pc_seq, pc_branch} pcsel_e;

    // Execute-stage controls
    typedef struct packed {
        alu_op_e               alu_func;
        opsel_e                opsel1;
        opsel_e                opsel2;
        wbsel_e                wbsel;
        logic [reg_addr_w-1:0] rd_addr;
        logic                  rf_w_en;
        logic                  mem_w_en;
    } id_ctrl_t;

    // Execute-stage operands
    typedef struct packed {
        logic [addr_len-1:0] pc;
        logic [xlen-1:0]     rs1_value;
        logic [xlen-1:0]     rs2_value;
        logic [xlen-1:0]     imm;
    } id_data_t;

endpackage

// ==== common/decode_if.sv ====
/*
 * Decoded instruction bundle. The decoder drives it combinationally and the
 * ID/EX register feeds and hazard logic read it.
 */
`timescale 1ns/100ps

interface decode_if;

    decode_pkg::id_ctrl_t                    ctrl;
    logic [decode_pkg::xlen-1:0]             imm;
    logic [decode_pkg::reg_addr_w-1:0]       rs1_addr;
    logic [decode_pkg::reg_addr_w-1:0]       rs2_addr;
    logic                                    is_load;

    modport decoder (output ctrl, imm, rs1_addr, rs2_addr, is_load);
    modport consumer (input ctrl, imm, rs1_addr, rs2_addr, is_load);

endinterface

// ==== hw/pipe_reg.sv ====
/*
 * Pipeline register with synchronous clear and stall hold. The payload type
 * is a parameter so one module carries both control and data.
 */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk) begin
        if (reset) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

// ==== hw/decode/instr_decoder.sv ====
/*
 * Combinational RV32IM decoder. Maps opcode, funct3 and funct7 to execute
 * controls, the immediate and the register file read addresses.
 */
`timescale 1ns/100ps

module instr_decoder (
    input  logic [decode_pkg::xlen-1:0] inst_i,
    decode_if.decoder                   dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [decode_pkg::reg_addr_w-1:0] rs1, rs2, rd;
    logic [decode_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic shift_alt, op_alt;

    decode_pkg::id_ctrl_t ctrl;
    logic [decode_pkg::xlen-1:0] imm;
    logic [decode_pkg::reg_addr_w-1:0] rs1_addr, rs2_addr;
    logic is_load;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign rd     = inst_i[11:7];

    assign imm_i = {{(decode_pkg::xlen-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(decode_pkg::xlen-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{(decode_pkg::xlen-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{(decode_pkg::xlen-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // Alternate funct7 is only legal for sub, sra and srai
    assign shift_alt = (funct3 == decode_pkg::f3_sr) && (funct7 == decode_pkg::funct7_alt);
    assign op_alt    = (funct7 == decode_pkg::funct7_alt) &&
                       (funct3 == decode_pkg::f3_add_sub || funct3 == decode_pkg::f3_sr);

    // Common funct3 map of OP and OP-IMM
    function automatic decode_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            decode_pkg::f3_add_sub: alu_sel = alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
            decode_pkg::f3_sll:     alu_sel = decode_pkg::alu_sll;
            decode_pkg::f3_slt:     alu_sel = decode_pkg::alu_slt;
            decode_pkg::f3_sltu:    alu_sel = decode_pkg::alu_sltu;
            decode_pkg::f3_xor:     alu_sel = decode_pkg::alu_xor;
            decode_pkg::f3_sr:      alu_sel = alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
            decode_pkg::f3_or:      alu_sel = decode_pkg::alu_or;
            default:                alu_sel = decode_pkg::alu_and;
        endcase
    endfunction

    // Register-writing ALU op with rs1 as first operand
    function automatic decode_pkg::id_ctrl_t alu_ctrl(
        input decode_pkg::alu_op_e               op,
        input decode_pkg::opsel_e                src2,
        input logic [decode_pkg::reg_addr_w-1:0] rd_a
    );
        alu_ctrl          = '0;
        alu_ctrl.alu_func = op;
        alu_ctrl.opsel1   = decode_pkg::opsel_rs1;
        alu_ctrl.opsel2   = src2;
        alu_ctrl.wbsel    = decode_pkg::wb_alu;
        alu_ctrl.rd_addr  = rd_a;
        alu_ctrl.rf_w_en  = 1'b1;
    endfunction

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        is_load  = 1'b0;
        case (opcode)
            decode_pkg::op_op_imm: begin
                if ((funct3 != decode_pkg::f3_sll && funct3 != decode_pkg::f3_sr) ||
                    funct7 == decode_pkg::funct7_base || shift_alt) begin
                    ctrl     = alu_ctrl(alu_sel(funct3, shift_alt), decode_pkg::opsel_imm, rd);
                    imm      = imm_i;
                    rs1_addr = rs1;
                end
            end
            decode_pkg::op_op: begin
                if (funct7 == decode_pkg::funct7_muldiv) begin
                    // funct3[2] separates divide/remainder from multiply
                    ctrl = alu_ctrl(funct3[2] ? decode_pkg::alu_div : decode_pkg::alu_mul,
                                    decode_pkg::opsel_rs2, rd);
                end else if (funct7 == decode_pkg::funct7_base || op_alt) begin
                    ctrl = alu_ctrl(alu_sel(funct3, op_alt), decode_pkg::opsel_rs2, rd);
                end
                if (ctrl.rf_w_en) begin
                    rs1_addr = rs1;
                    rs2_addr = rs2;
                end
            end
            decode_pkg::op_lui: begin
                ctrl.wbsel   = decode_pkg::wb_imm;
                ctrl.rd_addr = rd;
                ctrl.rf_w_en = 1'b1;
                imm          = imm_u;
            end
            decode_pkg::op_auipc: begin
                ctrl        = alu_ctrl(decode_pkg::alu_add, decode_pkg::opsel_imm, rd);
                ctrl.opsel1 = decode_pkg::opsel_pc;
                imm         = imm_u;
            end
            decode_pkg::op_jal: begin
                ctrl.wbsel   = decode_pkg::wb_pc4;
                ctrl.rd_addr = rd;
                ctrl.rf_w_en = 1'b1;
                imm          = imm_j;
            end
            decode_pkg::op_jalr: begin
                if (funct3 == decode_pkg::f3_jalr) begin
                    ctrl.wbsel   = decode_pkg::wb_pc4;
                    ctrl.rd_addr = rd;
                    ctrl.rf_w_en = 1'b1;
                    imm          = imm_i;
                    rs1_addr     = rs1;
                end
            end
            decode_pkg::op_branch: begin
                case (funct3)
                    decode_pkg::f3_beq, decode_pkg::f3_bne, decode_pkg::f3_blt,
                    decode_pkg::f3_bge, decode_pkg::f3_bltu, decode_pkg::f3_bgeu: begin
                        imm      = imm_b;
                        rs1_addr = rs1;
                        rs2_addr = rs2;
                    end
                    default: begin
                    end
                endcase
            end
            decode_pkg::op_load: begin
                case (funct3)
                    decode_pkg::f3_lb, decode_pkg::f3_lh, decode_pkg::f3_lw,
                    decode_pkg::f3_lbu, decode_pkg::f3_lhu: begin
                        ctrl       = alu_ctrl(decode_pkg::alu_add, decode_pkg::opsel_imm, rd);
                        ctrl.wbsel = decode_pkg::wb_dmem;
                        imm        = imm_i;
                        rs1_addr   = rs1;
                        is_load    = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            decode_pkg::op_store: begin
                case (funct3)
                    decode_pkg::f3_sb, decode_pkg::f3_sh, decode_pkg::f3_sw: begin
                        // Address is rs1 plus offset, rs2 carries the store data
                        ctrl          = alu_ctrl(decode_pkg::alu_add, decode_pkg::opsel_imm, '0);
                        ctrl.rf_w_en  = 1'b0;
                        ctrl.mem_w_en = 1'b1;
                        imm           = imm_s;
                        rs1_addr      = rs1;
                        rs2_addr      = rs2;
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase

        // No instruction writes both the register file and memory
        assert (!(ctrl.rf_w_en && ctrl.mem_w_en))
            else $error("decoder drives rf_w_en and mem_w_en together");
    end

    assign dec.ctrl     = ctrl;
    assign dec.imm      = imm;
    assign dec.rs1_addr = rs1_addr;
    assign dec.rs2_addr = rs2_addr;
    assign dec.is_load  = is_load;

endmodule

// ==== hw/decode/branch_unit.sv ====
/*
 * Resolves branches and jumps in the decode cycle. Gives the PC select and
 * the redirect target from the current instruction and register values.
 */
`timescale 1ns/100ps

module branch_unit (
    input  logic [decode_pkg::xlen-1:0]     inst_i,
    input  logic [decode_pkg::addr_len-1:0] pc_i,
    input  logic [decode_pkg::xlen-1:0]     rs1_value_i,
    input  logic [decode_pkg::xlen-1:0]     rs2_value_i,
    output decode_pkg::pcsel_e              pcsel_o,
    output logic [decode_pkg::addr_len-1:0] branch_tar_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [decode_pkg::xlen-1:0] imm_b, imm_j, imm_i;
    logic taken;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    assign imm_b = {{(decode_pkg::xlen-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_j = {{(decode_pkg::xlen-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};
    assign imm_i = {{(decode_pkg::xlen-12){inst_i[31]}}, inst_i[31:20]};

    // Branch condition
    always_comb begin
        case (funct3)
            decode_pkg::f3_beq:  taken = rs1_value_i == rs2_value_i;
            decode_pkg::f3_bne:  taken = rs1_value_i != rs2_value_i;
            decode_pkg::f3_blt:  taken = $signed(rs1_value_i) < $signed(rs2_value_i);
            decode_pkg::f3_bge:  taken = $signed(rs1_value_i) >= $signed(rs2_value_i);
            decode_pkg::f3_bltu: taken = rs1_value_i < rs2_value_i;
            decode_pkg::f3_bgeu: taken = rs1_value_i >= rs2_value_i;
            default:             taken = 1'b0;
        endcase
    end

    always_comb begin
        pcsel_o      = decode_pkg::pc_seq;
        branch_tar_o = '0;
        if (opcode == decode_pkg::op_branch && taken) begin
            pcsel_o      = decode_pkg::pc_branch;
            branch_tar_o = pc_i + imm_b;
        end else if (opcode == decode_pkg::op_jal) begin
            pcsel_o      = decode_pkg::pc_branch;
            branch_tar_o = pc_i + imm_j;
        end else if (opcode == decode_pkg::op_jalr && funct3 == decode_pkg::f3_jalr) begin
            pcsel_o      = decode_pkg::pc_branch;
            branch_tar_o = rs1_value_i + imm_i;
        end

        // Redirect only ever comes from a control-transfer opcode
        assert (pcsel_o != decode_pkg::pc_branch || opcode == decode_pkg::op_branch ||
                opcode == decode_pkg::op_jal || opcode == decode_pkg::op_jalr)
            else $error("pc_branch selected for opcode %b", opcode);
    end

endmodule

// ==== hw/decode/hazard_unit.sv ====
/*
 * Registers the load flag for the execute stage and detects back-to-back
 * multiply or divide operations.
 */
`timescale 1ns/100ps

module hazard_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,
    decode_if.consumer          dec,
    input  decode_pkg::alu_op_e ex_alu_func_i,
    output logic                load_flag_o,
    output logic                muldiv_hazard_o
);

    logic ex_is_muldiv;

    // A stalled load must not be seen twice downstream
    always_ff @(posedge clk) begin
        if (reset || stall_i) begin
            load_flag_o <= 1'b0;
        end else begin
            load_flag_o <= dec.is_load;
        end
    end

    assign ex_is_muldiv = (ex_alu_func_i == decode_pkg::alu_mul) ||
                          (ex_alu_func_i == decode_pkg::alu_div);

    // Same mul/div unit requested again while it is still busy in EX
    assign muldiv_hazard_o = ex_is_muldiv && (dec.ctrl.alu_func == ex_alu_func_i);

    assert property (@(posedge clk) stall_i |=> !load_flag_o)
        else $error("load_flag_o high in the cycle after a stall");

endmodule

// ==== hw/decode/decode_stage.sv ====
/*
 * RV32IM instruction decode stage. Decodes inst_i, resolves branches in the
 * same cycle and presents execute controls through the ID/EX register.
 */
`timescale 1ns/100ps

module decode_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [decode_pkg::addr_len-1:0]     pc_i,
    input  logic [decode_pkg::xlen-1:0]         inst_i,
    input  logic [decode_pkg::xlen-1:0]         rs1_value_i,
    input  logic [decode_pkg::xlen-1:0]         rs2_value_i,
    input  logic                                stall_i,
    output logic [decode_pkg::addr_len-1:0]     pc_o,
    output logic [decode_pkg::xlen-1:0]         rs1_value_o,
    output logic [decode_pkg::xlen-1:0]         rs2_value_o,
    output logic [decode_pkg::xlen-1:0]         imm_o,
    output decode_pkg::alu_op_e                 alu_func_o,
    output decode_pkg::opsel_e                  opsel1_o,
    output decode_pkg::opsel_e                  opsel2_o,
    output decode_pkg::wbsel_e                  wbsel_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rd_addr_o,
    output logic                                rf_w_en_o,
    output logic                                mem_w_en_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rs1_addr_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rs2_addr_o,
    output logic                                load_flag_o,
    output decode_pkg::pcsel_e                  pcsel_o,
    output logic [decode_pkg::addr_len-1:0]     branch_tar_o,
    output logic                                muldiv_hazard_o
);

    decode_if dec_bus ();

    decode_pkg::id_ctrl_t ex_ctrl;
    decode_pkg::id_data_t id_data;
    decode_pkg::id_data_t ex_data;

    instr_decoder u_decoder (
        .inst_i (inst_i),
        .dec    (dec_bus.decoder)
    );

    branch_unit u_branch (
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_value_i  (rs1_value_i),
        .rs2_value_i  (rs2_value_i),
        .pcsel_o      (pcsel_o),
        .branch_tar_o (branch_tar_o)
    );

    hazard_unit u_hazard (
        .clk             (clk),
        .reset           (reset),
        .stall_i         (stall_i),
        .dec             (dec_bus.consumer),
        .ex_alu_func_i   (ex_ctrl.alu_func),
        .load_flag_o     (load_flag_o),
        .muldiv_hazard_o (muldiv_hazard_o)
    );

    // ID/EX operand bundle
    assign id_data.pc        = pc_i;
    assign id_data.rs1_value = rs1_value_i;
    assign id_data.rs2_value = rs2_value_i;
    assign id_data.imm       = dec_bus.imm;

    pipe_reg #(.payload_t(decode_pkg::id_ctrl_t)) u_ctrl_reg (
        .clk     (clk),
        .reset   (reset),
        .stall_i (stall_i),
        .d_i     (dec_bus.ctrl),
        .q_o     (ex_ctrl)
    );

    pipe_reg #(.payload_t(decode_pkg::id_data_t)) u_data_reg (
        .clk     (clk),
        .reset   (reset),
        .stall_i (stall_i),
        .d_i     (id_data),
        .q_o     (ex_data)
    );

    assign rs1_addr_o  = dec_bus.rs1_addr;
    assign rs2_addr_o  = dec_bus.rs2_addr;

    assign pc_o        = ex_data.pc;
    assign rs1_value_o = ex_data.rs1_value;
    assign rs2_value_o = ex_data.rs2_value;
    assign imm_o       = ex_data.imm;
    assign alu_func_o  = ex_ctrl.alu_func;
    assign opsel1_o    = ex_ctrl.opsel1;
    assign opsel2_o    = ex_ctrl.opsel2;
    assign wbsel_o     = ex_ctrl.wbsel;
    assign rd_addr_o   = ex_ctrl.rd_addr;
    assign rf_w_en_o   = ex_ctrl.rf_w_en;
    assign mem_w_en_o  = ex_ctrl.mem_w_en;

endmodule

// ==== dv/tb_decode_stage.sv ====
/*
 * Self-checking testbench for decode_stage. Replays dv/decode_patterns.txt
 * one record per clock and checks the same-cycle and ID/EX outputs.
 */
`timescale 1ns/100ps

module tb_decode_stage;

    localparam int clk_period   = 100;
    localparam int drive_delay  = 10;
    localparam int reset_cycles = 10;
    localparam int max_records  = 64;
    localparam int num_fields   = 20;

    // Pattern file columns
    localparam int col_test  = 0;
    localparam int col_inst  = 1;
    localparam int col_pc    = 2;
    localparam int col_rs1v  = 3;
    localparam int col_rs2v  = 4;
    localparam int col_stall = 5;
    localparam int col_pcsel = 6;
    localparam int col_tar   = 7;
    localparam int col_rs1a  = 8;
    localparam int col_rs2a  = 9;
    localparam int col_alu   = 10;
    localparam int col_os1   = 11;
    localparam int col_os2   = 12;
    localparam int col_wb    = 13;
    localparam int col_rd    = 14;
    localparam int col_rfw   = 15;
    localparam int col_memw  = 16;
    localparam int col_imm   = 17;
    localparam int col_ld    = 18;
    localparam int col_mdh   = 19;

    logic                                clk;
    logic                                reset;
    logic                                stall_i;
    logic [decode_pkg::addr_len-1:0]     pc_i;
    logic [decode_pkg::xlen-1:0]         inst_i;
    logic [decode_pkg::xlen-1:0]         rs1_value_i;
    logic [decode_pkg::xlen-1:0]         rs2_value_i;
    logic [decode_pkg::addr_len-1:0]     pc_o;
    logic [decode_pkg::addr_len-1:0]     branch_tar_o;
    logic [decode_pkg::xlen-1:0]         rs1_value_o;
    logic [decode_pkg::xlen-1:0]         rs2_value_o;
    logic [decode_pkg::xlen-1:0]         imm_o;
    decode_pkg::alu_op_e                 alu_func_o;
    decode_pkg::opsel_e                  opsel1_o;
    decode_pkg::opsel_e                  opsel2_o;
    decode_pkg::wbsel_e                  wbsel_o;
    decode_pkg::pcsel_e                  pcsel_o;
    logic [decode_pkg::reg_addr_w-1:0]   rd_addr_o;
    logic [decode_pkg::reg_addr_w-1:0]   rs1_addr_o;
    logic [decode_pkg::reg_addr_w-1:0]   rs2_addr_o;
    logic                                rf_w_en_o;
    logic                                mem_w_en_o;
    logic                                load_flag_o;
    logic                                muldiv_hazard_o;

    logic [31:0] rec [max_records][num_fields];
    int          num_records;
    bit          loaded;
    int          checks;
    int          errors;
    int          test_errors;
    logic [31:0] exp_pc;
    logic [31:0] exp_rs1_value;
    logic [31:0] exp_rs2_value;

    decode_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        assert (actual === expected)
        else begin
            $display("ERR %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    function automatic string test_name(input logic [31:0] id);
        case (id)
            1:       test_name = "alu_decode";
            2:       test_name = "branches";
            3:       test_name = "jumps_upper_imm";
            4:       test_name = "load_store";
            5:       test_name = "stall";
            6:       test_name = "muldiv_hazard";
            default: test_name = "unknown";
        endcase
    endfunction

    task automatic report_test(input logic [31:0] id, input int n);
        $display("test %0d %s: %0d records, %0d errors", id, test_name(id), n, test_errors);
        test_errors = 0;
    endtask

    task automatic load_patterns(output bit ok);
        int    fd;
        int    n;
        string line;
        ok          = 1'b1;
        num_records = 0;
        fd = $fopen("dv/decode_patterns.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while (!$feof(fd) && num_records < max_records) begin
                n = $fgets(line, fd);
                // Skip blank and comment lines
                if (n > 1 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        rec[num_records][0], rec[num_records][1], rec[num_records][2],
                        rec[num_records][3], rec[num_records][4], rec[num_records][5],
                        rec[num_records][6], rec[num_records][7], rec[num_records][8],
                        rec[num_records][9], rec[num_records][10], rec[num_records][11],
                        rec[num_records][12], rec[num_records][13], rec[num_records][14],
                        rec[num_records][15], rec[num_records][16], rec[num_records][17],
                        rec[num_records][18], rec[num_records][19]);
                    if (n == num_fields) begin
                        num_records++;
                    end else begin
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
        if (num_records == 0) begin
            ok = 1'b0;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (reset_cycles) begin
            @(posedge clk);
            #drive_delay;
            // Random filler stimulus while the ID/EX register is held clear
            inst_i      = $urandom;
            pc_i        = $urandom;
            rs1_value_i = $urandom;
            rs2_value_i = $urandom;
        end
        check_value("alu_func_o", 32'(alu_func_o), 32'(decode_pkg::alu_nop));
        check_value("opsel1_o", 32'(opsel1_o), 32'(decode_pkg::opsel_rs1));
        check_value("opsel2_o", 32'(opsel2_o), 32'(decode_pkg::opsel_rs1));
        check_value("wbsel_o", 32'(wbsel_o), 32'(decode_pkg::wb_alu));
        check_value("rd_addr_o", 32'(rd_addr_o), 32'h0);
        check_value("rf_w_en_o", 32'(rf_w_en_o), 32'h0);
        check_value("mem_w_en_o", 32'(mem_w_en_o), 32'h0);
        check_value("imm_o", imm_o, 32'h0);
        check_value("pc_o", pc_o, 32'h0);
        check_value("rs1_value_o", rs1_value_o, 32'h0);
        check_value("rs2_value_o", rs2_value_o, 32'h0);
        check_value("load_flag_o", 32'(load_flag_o), 32'h0);
        reset = 1'b0;
    endtask

    task automatic check_comb(input int k);
        check_value("pcsel_o", 32'(pcsel_o), rec[k][col_pcsel]);
        check_value("branch_tar_o", branch_tar_o, rec[k][col_tar]);
        check_value("rs1_addr_o", 32'(rs1_addr_o), rec[k][col_rs1a]);
        check_value("rs2_addr_o", 32'(rs2_addr_o), rec[k][col_rs2a]);
        check_value("muldiv_hazard_o", 32'(muldiv_hazard_o), rec[k][col_mdh]);
    endtask

    task automatic check_registered(input int k);
        // Operands follow the stimulus unless the edge was stalled
        if (!rec[k][col_stall][0]) begin
            exp_pc        = rec[k][col_pc];
            exp_rs1_value = rec[k][col_rs1v];
            exp_rs2_value = rec[k][col_rs2v];
        end
        check_value("pc_o", pc_o, exp_pc);
        check_value("rs1_value_o", rs1_value_o, exp_rs1_value);
        check_value("rs2_value_o", rs2_value_o, exp_rs2_value);
        check_value("alu_func_o", 32'(alu_func_o), rec[k][col_alu]);
        check_value("opsel1_o", 32'(opsel1_o), rec[k][col_os1]);
        check_value("opsel2_o", 32'(opsel2_o), rec[k][col_os2]);
        check_value("wbsel_o", 32'(wbsel_o), rec[k][col_wb]);
        check_value("rd_addr_o", 32'(rd_addr_o), rec[k][col_rd]);
        check_value("rf_w_en_o", 32'(rf_w_en_o), rec[k][col_rfw]);
        check_value("mem_w_en_o", 32'(mem_w_en_o), rec[k][col_memw]);
        check_value("imm_o", imm_o, rec[k][col_imm]);
        check_value("load_flag_o", 32'(load_flag_o), rec[k][col_ld]);
    endtask

    task automatic run_patterns();
        logic [31:0] cur_test;
        int          test_records;
        cur_test     = rec[0][col_test];
        test_records = 0;
        for (int k = 0; k < num_records; k++) begin
            if (rec[k][col_test] != cur_test) begin
                report_test(cur_test, test_records);
                cur_test     = rec[k][col_test];
                test_records = 0;
            end
            inst_i      = rec[k][col_inst];
            pc_i        = rec[k][col_pc];
            rs1_value_i = rec[k][col_rs1v];
            rs2_value_i = rec[k][col_rs2v];
            stall_i     = rec[k][col_stall][0];
            // Same-cycle outputs are checked just before the edge and ID/EX just after it
            #(clk_period - 2 * drive_delay);
            check_comb(k);
            @(posedge clk);
            #(drive_delay / 2);
            check_registered(k);
            test_records++;
            #(drive_delay / 2);
        end
        report_test(cur_test, test_records);
    endtask

    // Watchdog sized from the number of records
    initial begin
        wait (loaded);
        #((num_records + 20) * clk_period);
        $display("Timeout: run did not finish within %0d ns", (num_records + 20) * clk_period);
        $display("Verification failed");
        $finish;
    end

    initial begin
        bit ok;
        reset         = 1'b1;
        stall_i       = 1'b0;
        pc_i          = '0;
        inst_i        = '0;
        rs1_value_i   = '0;
        rs2_value_i   = '0;
        checks        = 0;
        errors        = 0;
        test_errors   = 0;
        loaded        = 1'b0;
        exp_pc        = '0;
        exp_rs1_value = '0;
        exp_rs2_value = '0;
        void'($urandom(35));
        load_patterns(ok);
        if (!ok) begin
            $display("Pattern file dv/decode_patterns.txt is missing, empty or malformed");
            $display("Verification failed");
            $finish;
        end else begin
            loaded = 1'b1;
            apply_reset();
            run_patterns();
            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

// ==== dv/decode_patterns.txt ====
// test inst pc rs1_value rs2_value stall | pcsel branch_tar rs1_addr rs2_addr muldiv_hazard(col 20)
// ID/EX after the edge: alu_func opsel1 opsel2 wbsel rd rf_w_en mem_w_en imm load_flag
1 002081B3 00000100 00000005 00000007 0 0 00000000 01 02 1 0 1 0 03 1 0 00000000 0 0
1 407302B3 00000104 00000009 00000003 0 0 00000000 06 07 2 0 1 0 05 1 0 00000000 0 0
1 FFB00513 00000108 00000000 00000000 0 0 00000000 00 00 1 0 2 0 0A 1 0 FFFFFFFB 0 0
1 4034D213 0000010C 80000000 00000000 0 0 00000000 09 00 8 0 2 0 04 1 0 00000403 0 0
1 7FF43393 00000110 00000001 00000000 0 0 00000000 08 00 5 0 2 0 07 1 0 000007FF 0 0
1 003140B3 00000114 0000000F 000000F0 0 0 00000000 02 03 6 0 1 0 01 1 0 00000000 0 0
2 00208863 00000200 00000005 00000005 0 1 00000210 01 02 0 0 0 0 00 0 0 00000010 0 0
2 00208863 00000200 00000005 00000006 0 0 00000000 01 02 0 0 0 0 00 0 0 00000010 0 0
2 00209863 00000200 00000005 00000006 0 1 00000210 01 02 0 0 0 0 00 0 0 00000010 0 0
2 00209863 00000200 00000007 00000007 0 0 00000000 01 02 0 0 0 0 00 0 0 00000010 0 0
2 0020C863 00000200 FFFFFFFF 00000001 0 1 00000210 01 02 0 0 0 0 00 0 0 00000010 0 0
2 0020C863 00000200 00000001 FFFFFFFF 0 0 00000000 01 02 0 0 0 0 00 0 0 00000010 0 0
2 0020D863 00000200 00000001 FFFFFFFF 0 1 00000210 01 02 0 0 0 0 00 0 0 00000010 0 0
2 0020D863 00000200 FFFFFFFF 00000001 0 0 00000000 01 02 0 0 0 0 00 0 0 00000010 0 0
2 FE20ECE3 00000200 00000001 FFFFFFFF 0 1 000001F8 01 02 0 0 0 0 00 0 0 FFFFFFF8 0 0
2 FE20ECE3 00000200 FFFFFFFF 00000001 0 0 00000000 01 02 0 0 0 0 00 0 0 FFFFFFF8 0 0
2 0020F863 00000200 FFFFFFFF 00000001 0 1 00000210 01 02 0 0 0 0 00 0 0 00000010 0 0
2 0020F863 00000200 00000001 FFFFFFFF 0 0 00000000 01 02 0 0 0 0 00 0 0 00000010 0 0
3 100000EF 00000300 00000000 00000000 0 1 00000400 00 00 0 0 0 3 01 1 0 00000100 0 0
3 00C302E7 00000304 00001000 00000000 0 1 0000100C 06 00 0 0 0 3 05 1 0 0000000C 0 0
3 FFC100E7 00000308 00002000 00000000 0 1 00001FFC 02 00 0 0 0 3 01 1 0 FFFFFFFC 0 0
3 123453B7 0000030C 00000000 00000000 0 0 00000000 00 00 0 0 0 2 07 1 0 12345000 0 0
3 FFFFF417 00000310 00000000 00000000 0 0 00000000 00 00 1 3 2 0 08 1 0 FFFFF000 0 0
4 FF052483 00000400 00001010 00000000 0 0 00000000 0A 00 1 0 2 1 09 1 0 FFFFFFF0 1 0
4 00B62A23 00000404 00002000 DEADBEEF 0 0 00000000 0C 0B 1 0 2 0 00 0 1 00000014 0 0
4 FE111F23 00000408 00003000 0000BEEF 0 0 00000000 02 01 1 0 2 0 00 0 1 FFFFFFFE 0 0
5 00124183 00000500 00000100 00000000 0 0 00000000 04 00 1 0 2 1 03 1 0 00000001 1 0
5 002081B3 00000504 00000011 00000022 1 0 00000000 01 02 1 0 2 1 03 1 0 00000001 0 0
5 FF052483 00000508 00000033 00000044 1 0 00000000 0A 00 1 0 2 1 03 1 0 00000001 0 0
5 002081B3 0000050C 00000055 00000066 0 0 00000000 01 02 1 0 1 0 03 1 0 00000000 0 0
6 022081B3 00000600 00000006 00000007 0 0 00000000 01 02 B 0 1 0 03 1 0 00000000 0 0
6 022081B3 00000604 00000006 00000007 0 0 00000000 01 02 B 0 1 0 03 1 0 00000000 0 1
6 0220C233 00000608 00000006 00000007 0 0 00000000 01 02 C 0 1 0 04 1 0 00000000 0 0
6 002081B3 0000060C 00000006 00000007 0 0 00000000 01 02 1 0 1 0 03 1 0 00000000 0 0
6 022081B3 00000610 00000006 00000007 0 0 00000000 01 02 B 0 1 0 03 1 0 00000000 0 0
6 002081B3 00000614 00000006 00000007 0 0 00000000 01 02 1 0 1 0 03 1 0 00000000 0 0

// ==== rv_decode.f ====
common/decode_pkg.sv
common/decode_if.sv
hw/pipe_reg.sv
hw/decode/instr_decoder.sv
hw/decode/branch_unit.sv
hw/decode/hazard_unit.sv
hw/decode/decode_stage.sv
dv/tb_decode_stage.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_decode_stage
FILELIST  = rv_decode.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Verification passed
FAIL_MSG  = Verification failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
